/* hdl/sdio_data_pkg.sv */
/* Shared types, constants and state encodings for the SDIO card-side data controller.
   Modules take what they need through a wildcard import. */
`default_nettype none

package sdio_data_pkg;

  // Data byte on every bus
  typedef logic [7:0] byte_t;

  // Byte and block count, wide enough to hold 512
  typedef logic [9:0] data_cnt_t;

  // Count field as sent by the host, 0 means 512 or continuous
  typedef logic [8:0] host_cnt_t;

  // Register or memory address
  typedef logic [17:0] sdio_addr_t;

  // Function number, the CIA is function 0
  typedef logic [2:0] func_num_t;

  // Routed channel, 0 to 7 are functions and 8 is memory
  typedef logic [3:0] chan_sel_t;

  localparam int NUM_FUNCS = 8;
  localparam chan_sel_t MEM_CHAN = 4'd8;
  localparam data_cnt_t BLOCK_BYTES = 10'd512;

  // Transfer counter states
  typedef enum logic [1:0] {
    IDLE,
    CONFIG,
    ACTIVE,
    FINISHED
  } xfer_state_t;

  // Command bus single write engine
  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_WRITE,
    CMD_DONE
  } cmd_state_t;

endpackage

`default_nettype wire

/* hdl/transfer_counter.sv */
/* Counts bytes and blocks of one transfer, steps the address and flags the end.
   Returns to IDLE whenever i_activate drops, which also cancels a transfer. */
`timescale 1ns/10ps
`default_nettype none

module transfer_counter (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              i_activate,
  input  wire                              i_block_mode_flg,
  input  wire sdio_data_pkg::host_cnt_t    i_data_cnt,
  input  wire                              i_inc_addr_flg,
  input  wire sdio_data_pkg::sdio_addr_t   i_cmd_address,
  input  wire                              i_wr_stb,
  input  wire                              i_rd_stb,
  output logic                             o_hst_rdy,
  output logic                             o_finished,
  output sdio_data_pkg::data_cnt_t         o_total_data_cnt,
  output sdio_data_pkg::sdio_addr_t        o_address
);

  import sdio_data_pkg::*;

  xfer_state_t state;

  // Blocks requested and blocks started so far
  host_cnt_t   total_block_count;
  host_cnt_t   block_count;

  // Bytes moved in the current block
  data_cnt_t   data_count;

  // Block mode with a count of 0 runs until i_activate drops
  logic        continuous;

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= IDLE;
      o_hst_rdy         <= 1'b0;
      o_finished        <= 1'b0;
      o_total_data_cnt  <= '0;
      o_address         <= '0;
      total_block_count <= '0;
      block_count       <= '0;
      data_count        <= '0;
      continuous        <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          o_hst_rdy   <= 1'b0;
          o_finished  <= 1'b0;
          block_count <= '0;
          data_count  <= '0;
          o_address   <= i_cmd_address;
          if (i_block_mode_flg) begin
            total_block_count <= i_data_cnt;
            continuous        <= (i_data_cnt == '0);
          end else begin
            total_block_count <= '0;
            continuous        <= 1'b0;
          end
          if (i_activate) begin
            state <= CONFIG;
          end
        end

        CONFIG: begin
          // New block, so the byte count starts over
          data_count <= '0;
          o_hst_rdy  <= 1'b0;
          if (i_block_mode_flg) begin
            o_total_data_cnt <= BLOCK_BYTES;
            if (!continuous) begin
              block_count <= block_count + 1'b1;
            end
          end else if (i_data_cnt == '0) begin
            o_total_data_cnt <= BLOCK_BYTES;
          end else begin
            o_total_data_cnt <= data_cnt_t'(i_data_cnt);
          end
          state <= ACTIVE;
        end

        ACTIVE: begin
          if (data_count < o_total_data_cnt) begin
            o_hst_rdy <= 1'b1;
            if (i_wr_stb || i_rd_stb) begin
              data_count <= data_count + 1'b1;
              if (i_inc_addr_flg) begin
                o_address <= o_address + 1'b1;
              end
            end
          end else begin
            // Block complete
            o_hst_rdy <= 1'b0;
            if (continuous || (block_count < total_block_count)) begin
              state <= CONFIG;
            end else begin
              state <= FINISHED;
            end
          end
        end

        FINISHED: begin
          o_finished <= 1'b1;
        end

        default: begin
          state <= IDLE;
        end
      endcase

      // Dropping i_activate ends or cancels the transfer from any state
      if (!i_activate) begin
        state      <= IDLE;
        o_hst_rdy  <= 1'b0;
        o_finished <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_source_arbiter.sv */
/* Hands the shared function bus to the command bus or the data PHY.
   Also issues the single command-bus write once the target channel is ready. */
`timescale 1ns/10ps
`default_nettype none

module bus_source_arbiter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        i_cmd_bus_sel,
  input  wire                        i_activate,
  input  wire                        i_write_flg,
  input  wire sdio_data_pkg::byte_t  i_cmd_wr_data,
  input  wire                        i_data_phy_wr_stb,
  input  wire sdio_data_pkg::byte_t  i_data_phy_wr_data,
  input  wire                        i_rd_stb,
  input  wire sdio_data_pkg::byte_t  i_rd_data,
  input  wire                        i_com_rdy,
  output sdio_data_pkg::byte_t       o_cmd_rd_data,
  output logic                       o_data_phy_rd_stb,
  output sdio_data_pkg::byte_t       o_data_phy_rd_data,
  output logic                       o_data_phy_com_rdy,
  output logic                       o_data_phy_activate,
  output logic                       o_wr_stb,
  output sdio_data_pkg::byte_t       o_wr_data
);

  import sdio_data_pkg::*;

  cmd_state_t cmd_state;
  logic       cmd_wr_stb;

  // Read side, the unselected source sees zeros
  assign o_cmd_rd_data       = i_cmd_bus_sel ? i_rd_data : '0;
  assign o_data_phy_rd_stb   = i_cmd_bus_sel ? 1'b0 : i_rd_stb;
  assign o_data_phy_rd_data  = i_cmd_bus_sel ? '0 : i_rd_data;
  assign o_data_phy_com_rdy  = i_cmd_bus_sel ? 1'b0 : i_com_rdy;
  assign o_data_phy_activate = i_cmd_bus_sel ? 1'b0 : i_activate;

  // Write side onto the function bus
  assign o_wr_stb  = i_cmd_bus_sel ? cmd_wr_stb : i_data_phy_wr_stb;
  assign o_wr_data = i_cmd_bus_sel ? i_cmd_wr_data : i_data_phy_wr_data;

  // One write per activation, after the target reports ready
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_state  <= CMD_IDLE;
      cmd_wr_stb <= 1'b0;
    end else begin
      cmd_wr_stb <= 1'b0;
      case (cmd_state)
        CMD_IDLE: begin
          if (i_cmd_bus_sel && i_activate && i_write_flg) begin
            cmd_state <= CMD_WRITE;
          end
        end

        CMD_WRITE: begin
          if (!i_activate) begin
            cmd_state <= CMD_IDLE;
          end else if (i_com_rdy) begin
            cmd_wr_stb <= 1'b1;
            cmd_state  <= CMD_DONE;
          end
        end

        CMD_DONE: begin
          // Hold here so the byte is written only once
          if (!i_activate) begin
            cmd_state <= CMD_IDLE;
          end
        end

        default: begin
          cmd_state <= CMD_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/func_router.sv */
/* Steers the shared write bus to the selected function or memory channel
   and returns that channel's read strobe, read data and ready. */
`timescale 1ns/10ps
`default_nettype none

module func_router (
  input  wire                                                      i_mem_sel,
  input  wire sdio_data_pkg::func_num_t                            i_func_sel,
  input  wire                                                      i_wr_stb,
  input  wire sdio_data_pkg::byte_t                                i_wr_data,
  input  wire                                                      i_hst_rdy,
  input  wire                                                      i_activate,

  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                      o_func_wr_stb,
  output sdio_data_pkg::byte_t [sdio_data_pkg::NUM_FUNCS-1:0]      o_func_wr_data,
  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                      o_func_hst_rdy,
  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                      o_func_activate,
  input  wire  [sdio_data_pkg::NUM_FUNCS-1:0]                      i_func_rd_stb,
  input  wire sdio_data_pkg::byte_t [sdio_data_pkg::NUM_FUNCS-1:0] i_func_rd_data,
  input  wire  [sdio_data_pkg::NUM_FUNCS-1:0]                      i_func_com_rdy,

  output logic                                                     o_mem_wr_stb,
  output sdio_data_pkg::byte_t                                     o_mem_wr_data,
  output logic                                                     o_mem_hst_rdy,
  output logic                                                     o_mem_activate,
  input  wire                                                      i_mem_rd_stb,
  input  wire sdio_data_pkg::byte_t                                i_mem_rd_data,
  input  wire                                                      i_mem_com_rdy,

  output logic                                                     o_rd_stb,
  output sdio_data_pkg::byte_t                                     o_rd_data,
  output logic                                                     o_com_rdy
);

  import sdio_data_pkg::*;

  chan_sel_t chan_sel;
  logic      chan_rdy;

  // Memory overrides the function number
  assign chan_sel  = i_mem_sel ? MEM_CHAN : {1'b0, i_func_sel};
  assign o_com_rdy = chan_rdy & i_hst_rdy;

  always_comb begin
    o_func_wr_stb   = '0;
    o_func_wr_data  = '0;
    o_func_hst_rdy  = '0;
    o_func_activate = '0;
    o_mem_wr_stb    = 1'b0;
    o_mem_wr_data   = '0;
    o_mem_hst_rdy   = 1'b0;
    o_mem_activate  = 1'b0;
    o_rd_stb        = 1'b0;
    o_rd_data       = '0;
    chan_rdy        = 1'b0;

    if (chan_sel == MEM_CHAN) begin
      o_mem_wr_stb   = i_wr_stb;
      o_mem_wr_data  = i_wr_data;
      o_mem_hst_rdy  = i_hst_rdy;
      o_mem_activate = i_activate;
      o_rd_stb       = i_mem_rd_stb;
      o_rd_data      = i_mem_rd_data;
      chan_rdy       = i_mem_com_rdy;
    end

    // Only the addressed function sees the bus
    for (int i = 0; i < NUM_FUNCS; i++) begin
      if (chan_sel == chan_sel_t'(i)) begin
        o_func_wr_stb[i]   = i_wr_stb;
        o_func_wr_data[i]  = i_wr_data;
        o_func_hst_rdy[i]  = i_hst_rdy;
        o_func_activate[i] = i_activate;
        o_rd_stb           = i_func_rd_stb[i];
        o_rd_data          = i_func_rd_data[i];
        chan_rdy           = i_func_com_rdy[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/sdio_data_control.sv */
/* Top level of the SDIO data controller. Connects the command bus or data PHY
   to one of eight function channels or memory and counts the transfer. */
`timescale 1ns/10ps
`default_nettype none

module sdio_data_control (
  input  wire                                                   clk,
  input  wire                                                   rst,

  input  wire                                                   i_write_flg,
  input  wire                                                   i_block_mode_flg,
  input  wire sdio_data_pkg::host_cnt_t                         i_data_cnt,
  input  wire                                                   i_inc_addr_flg,
  input  wire sdio_data_pkg::sdio_addr_t                        i_cmd_address,
  input  wire                                                   i_activate,
  output logic                                                  o_finished,
  output sdio_data_pkg::data_cnt_t                              o_total_data_cnt,
  output sdio_data_pkg::sdio_addr_t                             o_address,

  input  wire                                                   i_cmd_bus_sel,
  input  wire                                                   i_mem_sel,
  input  wire sdio_data_pkg::func_num_t                         i_func_sel,

  // Command bus
  input  wire sdio_data_pkg::byte_t                             i_cmd_wr_data,
  output sdio_data_pkg::byte_t                                  o_cmd_rd_data,

  // Data PHY
  input  wire                                                   i_data_phy_wr_stb,
  input  wire sdio_data_pkg::byte_t                             i_data_phy_wr_data,
  output logic                                                  o_data_phy_rd_stb,
  output sdio_data_pkg::byte_t                                  o_data_phy_rd_data,
  output logic                                                  o_data_phy_com_rdy,
  output logic                                                  o_data_phy_activate,

  // Function channels, indexed by function number
  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                   o_func_wr_stb,
  output sdio_data_pkg::byte_t [sdio_data_pkg::NUM_FUNCS-1:0]   o_func_wr_data,
  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                   o_func_hst_rdy,
  output logic [sdio_data_pkg::NUM_FUNCS-1:0]                   o_func_activate,
  input  wire  [sdio_data_pkg::NUM_FUNCS-1:0]                   i_func_rd_stb,
  input  wire sdio_data_pkg::byte_t [sdio_data_pkg::NUM_FUNCS-1:0] i_func_rd_data,
  input  wire  [sdio_data_pkg::NUM_FUNCS-1:0]                   i_func_com_rdy,

  // Memory channel
  output logic                                                  o_mem_wr_stb,
  output sdio_data_pkg::byte_t                                  o_mem_wr_data,
  output logic                                                  o_mem_hst_rdy,
  output logic                                                  o_mem_activate,
  input  wire                                                   i_mem_rd_stb,
  input  wire sdio_data_pkg::byte_t                             i_mem_rd_data,
  input  wire                                                   i_mem_com_rdy
);

  import sdio_data_pkg::*;

  // Shared function bus
  logic  wr_stb;
  byte_t wr_data;
  logic  rd_stb;
  byte_t rd_data;
  logic  com_rdy;
  logic  hst_rdy;

  transfer_counter u_transfer_counter (
    .clk              (clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_block_mode_flg (i_block_mode_flg),
    .i_data_cnt       (i_data_cnt),
    .i_inc_addr_flg   (i_inc_addr_flg),
    .i_cmd_address    (i_cmd_address),
    .i_wr_stb         (wr_stb),
    .i_rd_stb         (rd_stb),
    .o_hst_rdy        (hst_rdy),
    .o_finished       (o_finished),
    .o_total_data_cnt (o_total_data_cnt),
    .o_address        (o_address)
  );

  bus_source_arbiter u_bus_source_arbiter (
    .clk                 (clk),
    .rst                 (rst),
    .i_cmd_bus_sel       (i_cmd_bus_sel),
    .i_activate          (i_activate),
    .i_write_flg         (i_write_flg),
    .i_cmd_wr_data       (i_cmd_wr_data),
    .i_data_phy_wr_stb   (i_data_phy_wr_stb),
    .i_data_phy_wr_data  (i_data_phy_wr_data),
    .i_rd_stb            (rd_stb),
    .i_rd_data           (rd_data),
    .i_com_rdy           (com_rdy),
    .o_cmd_rd_data       (o_cmd_rd_data),
    .o_data_phy_rd_stb   (o_data_phy_rd_stb),
    .o_data_phy_rd_data  (o_data_phy_rd_data),
    .o_data_phy_com_rdy  (o_data_phy_com_rdy),
    .o_data_phy_activate (o_data_phy_activate),
    .o_wr_stb            (wr_stb),
    .o_wr_data           (wr_data)
  );

  func_router u_func_router (
    .i_mem_sel       (i_mem_sel),
    .i_func_sel      (i_func_sel),
    .i_wr_stb        (wr_stb),
    .i_wr_data       (wr_data),
    .i_hst_rdy       (hst_rdy),
    .i_activate      (i_activate),
    .o_func_wr_stb   (o_func_wr_stb),
    .o_func_wr_data  (o_func_wr_data),
    .o_func_hst_rdy  (o_func_hst_rdy),
    .o_func_activate (o_func_activate),
    .i_func_rd_stb   (i_func_rd_stb),
    .i_func_rd_data  (i_func_rd_data),
    .i_func_com_rdy  (i_func_com_rdy),
    .o_mem_wr_stb    (o_mem_wr_stb),
    .o_mem_wr_data   (o_mem_wr_data),
    .o_mem_hst_rdy   (o_mem_hst_rdy),
    .o_mem_activate  (o_mem_activate),
    .i_mem_rd_stb    (i_mem_rd_stb),
    .i_mem_rd_data   (i_mem_rd_data),
    .i_mem_com_rdy   (i_mem_com_rdy),
    .o_rd_stb        (rd_stb),
    .o_rd_data       (rd_data),
    .o_com_rdy       (com_rdy)
  );

endmodule

`default_nettype wire

/* test/tb_tasks.svh */
/* Directed tests, LFSR and check helpers of the data controller testbench.
   Included inside the testbench module, so the tasks drive its signals directly. */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Right-shifting Galois LFSR
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] random_bits(input int n);
  logic [31:0] val;
  val = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_step(lfsr_state);
    val = {val[30:0], lfsr_state[0]};
  end
  return val;
endfunction

task automatic report_mismatch(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
  $display("ERROR %s: expected %0h, actual %0h", test, exp, act);
  error_count++;
endtask

task automatic report_failure(input string test, input string what);
  $display("%s: %s", test, what);
  error_count++;
endtask

task automatic finish_test(input string test, input int errs_before);
  tests_run++;
  if (error_count == errs_before) begin
    $display("test %s: ok", test);
  end else begin
    tests_failed++;
    $display("test %s: %0d errors", test, error_count - errs_before);
  end
endtask

task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

// Channel models idle with ready held high
task automatic idle_inputs();
  i_write_flg        = 1'b0;
  i_block_mode_flg   = 1'b0;
  i_data_cnt         = '0;
  i_inc_addr_flg     = 1'b0;
  i_cmd_address      = '0;
  i_activate         = 1'b0;
  i_cmd_bus_sel      = 1'b0;
  i_mem_sel          = 1'b0;
  i_func_sel         = '0;
  i_cmd_wr_data      = '0;
  i_data_phy_wr_stb  = 1'b0;
  i_data_phy_wr_data = '0;
  i_func_rd_stb      = '0;
  i_func_rd_data     = '0;
  i_func_com_rdy     = '1;
  i_mem_rd_stb       = 1'b0;
  i_mem_rd_data      = '0;
  i_mem_com_rdy      = 1'b1;
endtask

task automatic check_quiet(input string test);
  logic [30:0] levels;
  levels = {o_func_wr_stb, o_func_hst_rdy, o_func_activate, o_mem_wr_stb, o_mem_hst_rdy,
            o_mem_activate, o_data_phy_rd_stb, o_data_phy_com_rdy, o_data_phy_activate,
            o_finished};
  if (levels !== '0) report_mismatch(test, 0, levels);
  if (o_address !== '0) report_mismatch(test, 0, o_address);
  if (o_total_data_cnt !== '0) report_mismatch(test, 0, o_total_data_cnt);
endtask

// PHY strobes one byte once the target is ready
// Channel 8 stands for memory
task automatic phy_write_byte(input string test, input int chan, input byte_t b);
  logic [8:0] exp_stb;
  byte_t      act_data;
  while (o_data_phy_com_rdy !== 1'b1) begin
    next_cycle();
  end
  i_data_phy_wr_stb  = 1'b1;
  i_data_phy_wr_data = b;
  #1;
  exp_stb  = 9'b1 << chan;
  act_data = (chan == MEM_CHAN) ? o_mem_wr_data : o_func_wr_data[chan];
  if ({o_mem_wr_stb, o_func_wr_stb} !== exp_stb) begin
    report_mismatch(test, exp_stb, {o_mem_wr_stb, o_func_wr_stb});
  end
  if (act_data !== b) report_mismatch(test, b, act_data);
  // Activate and host-ready reach the target channel only
  if ({o_mem_activate, o_func_activate} !== exp_stb) begin
    report_mismatch(test, exp_stb, {o_mem_activate, o_func_activate});
  end
  if ({o_mem_hst_rdy, o_func_hst_rdy} !== exp_stb) begin
    report_mismatch(test, exp_stb, {o_mem_hst_rdy, o_func_hst_rdy});
  end
  if (o_data_phy_activate !== 1'b1) report_mismatch(test, 1, o_data_phy_activate);
  next_cycle();
  i_data_phy_wr_stb = 1'b0;
  next_cycle();
  if (o_finished !== 1'b0) report_failure(test, "o_finished rose too early");
endtask

// Memory model answers with one LFSR byte
task automatic mem_read_byte(input string test);
  logic [31:0] rnd;
  byte_t       b;
  while (o_mem_hst_rdy !== 1'b1) begin
    next_cycle();
  end
  rnd           = random_bits(8);
  b             = rnd[7:0];
  i_mem_rd_stb  = 1'b1;
  i_mem_rd_data = b;
  #1;
  if (o_data_phy_rd_stb !== 1'b1) report_mismatch(test, 1, o_data_phy_rd_stb);
  if (o_data_phy_rd_data !== b) report_mismatch(test, b, o_data_phy_rd_data);
  if (o_cmd_rd_data !== 8'h00) report_mismatch(test, 0, o_cmd_rd_data);
  next_cycle();
  i_mem_rd_stb = 1'b0;
  next_cycle();
  if (o_finished !== 1'b0) report_failure(test, "o_finished rose too early");
endtask

task automatic wait_finished(input string test);
  int cycles;
  cycles = 0;
  while (o_finished !== 1'b1 && cycles < 20) begin
    next_cycle();
    cycles++;
  end
  if (o_finished !== 1'b1) report_failure(test, "o_finished did not rise after the last byte");
endtask

// Ends the transfer and checks the channels one edge later
task automatic drop_activate(input string test);
  logic [17:0] levels;
  i_activate = 1'b0;
  next_cycle();
  levels = {o_func_activate, o_func_hst_rdy, o_mem_activate, o_mem_hst_rdy};
  if (levels !== '0) report_mismatch(test, 0, levels);
  if (o_finished !== 1'b0) report_failure(test, "o_finished still high after i_activate fell");
  idle_inputs();
  next_cycle();
endtask

task automatic test_reset_state();
  string name;
  int    errs;
  name = "reset_state";
  errs = error_count;
  rst  = 1'b1;
  repeat (5) @(posedge clk);
  #1;
  check_quiet(name);
  repeat (5) @(posedge clk);
  #1;
  check_quiet(name);
  rst = 1'b0;
  next_cycle();
  check_quiet(name);
  finish_test(name, errs);
endtask

task automatic test_phy_byte_write();
  string       name;
  int          errs;
  int          func;
  int          count;
  logic [31:0] rnd;
  sdio_addr_t  start;
  name   = "phy_byte_write";
  errs   = error_count;
  rnd    = random_bits(3);
  func   = rnd;
  rnd    = random_bits(5);
  count  = 1 + (rnd % 20);
  rnd    = random_bits(18);
  start  = rnd[17:0];
  i_func_sel     = func[2:0];
  i_write_flg    = 1'b1;
  i_data_cnt     = count[8:0];
  i_inc_addr_flg = 1'b1;
  i_cmd_address  = start;
  i_activate     = 1'b1;
  for (int j = 0; j < count; j++) begin
    rnd = random_bits(8);
    phy_write_byte(name, func, rnd[7:0]);
  end
  if (o_total_data_cnt !== count[9:0]) report_mismatch(name, count, o_total_data_cnt);
  if (o_address !== start + count[17:0]) report_mismatch(name, start + count[17:0], o_address);
  wait_finished(name);
  drop_activate(name);
  finish_test(name, errs);
endtask

task automatic test_phy_mem_read();
  string name;
  int    errs;
  name = "phy_mem_read";
  errs = error_count;
  i_mem_sel  = 1'b1;
  i_data_cnt = '0;
  i_activate = 1'b1;
  repeat (512) mem_read_byte(name);
  if (o_total_data_cnt !== 10'd512) report_mismatch(name, 512, o_total_data_cnt);
  wait_finished(name);
  drop_activate(name);
  finish_test(name, errs);
endtask

task automatic test_block_write();
  string       name;
  int          errs;
  int          func;
  logic [31:0] rnd;
  name = "block_write";
  errs = error_count;
  rnd  = random_bits(3);
  func = rnd;
  i_func_sel       = func[2:0];
  i_write_flg      = 1'b1;
  i_block_mode_flg = 1'b1;
  i_data_cnt       = 9'd2;
  i_cmd_address    = 18'h2_0a5c;
  i_activate       = 1'b1;
  // Two blocks of 512
  for (int j = 0; j < 1024; j++) begin
    rnd = random_bits(8);
    phy_write_byte(name, func, rnd[7:0]);
  end
  if (o_total_data_cnt !== 10'd512) report_mismatch(name, 512, o_total_data_cnt);
  if (o_address !== 18'h2_0a5c) report_mismatch(name, 18'h2_0a5c, o_address);
  wait_finished(name);
  drop_activate(name);
  finish_test(name, errs);
endtask

task automatic test_cmd_single_write();
  string       name;
  int          errs;
  int          func;
  int          hold;
  int          strobes;
  logic [31:0] rnd;
  byte_t       data;
  logic [10:0] phy_out;
  name = "cmd_single_write";
  errs = error_count;
  rnd  = random_bits(3);
  func = rnd;
  rnd  = random_bits(8);
  data = rnd[7:0];
  rnd  = random_bits(4);
  hold = 2 + rnd;
  strobes = 0;
  i_cmd_bus_sel        = 1'b1;
  i_write_flg          = 1'b1;
  i_func_sel           = func[2:0];
  i_cmd_wr_data        = data;
  i_data_cnt           = 9'd1;
  i_func_com_rdy[func] = 1'b0;
  i_activate           = 1'b1;
  for (int j = 0; j < hold + 12; j++) begin
    if (j == hold) i_func_com_rdy[func] = 1'b1;
    next_cycle();
    if (o_func_wr_stb[func] === 1'b1) begin
      strobes++;
      if (j < hold) report_failure(name, "write strobe while the function was not ready");
      if (o_func_wr_data[func] !== data) report_mismatch(name, data, o_func_wr_data[func]);
    end
    if (({o_mem_wr_stb, o_func_wr_stb} & ~(9'b1 << func)) !== '0) begin
      report_failure(name, "write strobe on a channel that was not selected");
    end
    phy_out = {o_data_phy_rd_stb, o_data_phy_rd_data, o_data_phy_com_rdy, o_data_phy_activate};
    if (phy_out !== '0) report_mismatch(name, 0, phy_out);
  end
  if (strobes != 1) report_mismatch(name, 1, strobes);
  drop_activate(name);
  finish_test(name, errs);
endtask

// Continuous block mode into memory, cancelled by dropping i_activate
task automatic test_continuous_cancel();
  string       name;
  int          errs;
  logic [31:0] rnd;
  name = "continuous_cancel";
  errs = error_count;
  i_mem_sel        = 1'b1;
  i_write_flg      = 1'b1;
  i_block_mode_flg = 1'b1;
  i_data_cnt       = '0;
  i_activate       = 1'b1;
  for (int j = 0; j < 1100; j++) begin
    rnd = random_bits(8);
    phy_write_byte(name, MEM_CHAN, rnd[7:0]);
  end
  drop_activate(name);
  finish_test(name, errs);
endtask

`endif

/* test/tb_sdio_data_control.sv */
/* Directed testbench for the SDIO data controller. Runs PHY, memory and command-bus
   transfers through the DUT and checks routing, byte counts, address and the finished flag. */
`timescale 1ns/10ps
`default_nettype none

module tb_sdio_data_control;

  import sdio_data_pkg::*;

  localparam int CLK_PERIOD = 10;

  // Worst case of each test in cycles with up to three cycles per byte
  localparam int WORST_CYCLES = 30 + (20 * 3 + 40) + (512 * 3 + 40) + (1024 * 3 + 60)
                                + 60 + (1100 * 3 + 60);

  logic                      clk;
  logic                      rst;
  logic                      i_write_flg;
  logic                      i_block_mode_flg;
  host_cnt_t                 i_data_cnt;
  logic                      i_inc_addr_flg;
  sdio_addr_t                i_cmd_address;
  logic                      i_activate;
  logic                      o_finished;
  data_cnt_t                 o_total_data_cnt;
  sdio_addr_t                o_address;
  logic                      i_cmd_bus_sel;
  logic                      i_mem_sel;
  func_num_t                 i_func_sel;
  byte_t                     i_cmd_wr_data;
  byte_t                     o_cmd_rd_data;
  logic                      i_data_phy_wr_stb;
  byte_t                     i_data_phy_wr_data;
  logic                      o_data_phy_rd_stb;
  byte_t                     o_data_phy_rd_data;
  logic                      o_data_phy_com_rdy;
  logic                      o_data_phy_activate;
  logic [NUM_FUNCS-1:0]      o_func_wr_stb;
  byte_t [NUM_FUNCS-1:0]     o_func_wr_data;
  logic [NUM_FUNCS-1:0]      o_func_hst_rdy;
  logic [NUM_FUNCS-1:0]      o_func_activate;
  logic [NUM_FUNCS-1:0]      i_func_rd_stb;
  byte_t [NUM_FUNCS-1:0]     i_func_rd_data;
  logic [NUM_FUNCS-1:0]      i_func_com_rdy;
  logic                      o_mem_wr_stb;
  byte_t                     o_mem_wr_data;
  logic                      o_mem_hst_rdy;
  logic                      o_mem_activate;
  logic                      i_mem_rd_stb;
  byte_t                     i_mem_rd_data;
  logic                      i_mem_com_rdy;

  // Run bookkeeping and random source
  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr_state;

  always #(CLK_PERIOD / 2) clk = ~clk;

  sdio_data_control UUT (.*);

  `include "tb_tasks.svh"

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = 32'h1a31_0656;
    idle_inputs();

    test_reset_state();
    test_phy_byte_write();
    test_phy_mem_read();
    test_block_write();
    test_cmd_single_write();
    test_continuous_cancel();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Ends a run that hangs waiting on the DUT
  initial begin
    #(2 * WORST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, a test kept waiting on the DUT and the run was stopped");
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+test
hdl/sdio_data_pkg.sv
hdl/transfer_counter.sv
hdl/bus_source_arbiter.sv
hdl/func_router.sv
hdl/sdio_data_control.sv
test/tb_sdio_data_control.sv

/* Bender.yml */
package:
  name: sdio_data_control

sources:
  - files:
      - hdl/sdio_data_pkg.sv
      - hdl/transfer_counter.sv
      - hdl/bus_source_arbiter.sv
      - hdl/func_router.sv
      - hdl/sdio_data_control.sv
  - target: simulation
    include_dirs:
      - test
    files:
      - test/tb_sdio_data_control.sv
